/* rtl/md_pkg.sv */
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Multiply/divide unit shared types
// Width constants, opcode views and the request/response words
////////////////////////////////////////////////////////////////////////////

package md_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Data width of the core
  localparam int unsigned XLEN = 32;
  // Operand half used by the 16x16 kernel
  localparam int unsigned HLEN = XLEN / 2;
  // Width of the funct3 opcode
  localparam int unsigned MD_OP_W = 3;

  // Values of high_mode in the multiply view
  localparam logic [MD_OP_W-2:0] MD_HI_MUL    = 2'd0;
  localparam logic [MD_OP_W-2:0] MD_HI_MULH   = 2'd1;
  localparam logic [MD_OP_W-2:0] MD_HI_MULHSU = 2'd2;
  localparam logic [MD_OP_W-2:0] MD_HI_MULHU  = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode
  ////////////////////////////////////////////////////////////////////////////

  // Multiply reading of funct3
  typedef struct packed {
    logic                is_div;
    logic [MD_OP_W-2:0]  high_mode;
  } md_mul_view_t;

  // Divide reading of funct3
  typedef struct packed {
    logic is_div;
    logic is_rem;
    logic is_unsigned;
  } md_div_view_t;

  // One funct3 word, two decodes
  typedef union packed {
    md_mul_view_t mul;
    md_div_view_t div;
  } md_op_u;

  ////////////////////////////////////////////////////////////////////////////
  // Request, response and operand signedness
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    md_op_u            op;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
  } md_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
  } md_rsp_t;

  typedef struct packed {
    logic a_signed;
    logic b_signed;
  } md_sign_t;

endpackage

`default_nettype wire

/* rtl/md_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Multiply/divide controller
// Takes requests, starts one engine and returns its result as a strobe
////////////////////////////////////////////////////////////////////////////

module md_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  md_pkg::md_req_t             req_i,
  output logic                        busy_o,
  output logic                        rsp_valid_o,
  output md_pkg::md_rsp_t             rsp_o,
  output logic                        mult_start_o,
  output logic                        div_start_o,
  output md_pkg::md_op_u              op_o,
  output logic [md_pkg::XLEN-1:0]     op_a_o,
  output logic [md_pkg::XLEN-1:0]     op_b_o,
  output md_pkg::md_sign_t            sign_o,
  input  logic                        mult_done_i,
  input  logic [md_pkg::XLEN-1:0]     mult_result_i,
  input  logic                        div_done_i,
  input  logic [md_pkg::XLEN-1:0]     div_result_i
);

  logic             accept;
  logic             eng_done;
  logic             busy_q;
  logic             rsp_valid_q;
  logic             mult_start_q;
  logic             div_start_q;
  md_pkg::md_req_t  req_q;
  md_pkg::md_sign_t sign_d;
  md_pkg::md_sign_t sign_q;
  md_pkg::md_rsp_t  rsp_q;

  assign accept   = req_valid_i & ~busy_q;
  assign eng_done = mult_done_i | div_done_i;

  // Operand signedness from funct3
  always_comb begin
    sign_d = '0;
    if (req_i.op.div.is_div) begin
      sign_d.a_signed = ~req_i.op.div.is_unsigned;
      sign_d.b_signed = ~req_i.op.div.is_unsigned;
    end else begin
      case (req_i.op.mul.high_mode)
        md_pkg::MD_HI_MULH: begin
          sign_d.a_signed = 1'b1;
          sign_d.b_signed = 1'b1;
        end
        md_pkg::MD_HI_MULHSU: sign_d.a_signed = 1'b1;
        md_pkg::MD_HI_MUL, md_pkg::MD_HI_MULHU: sign_d = '0;
        default: sign_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      rsp_valid_q  <= 1'b0;
      mult_start_q <= 1'b0;
      div_start_q  <= 1'b0;
    end else begin
      // Busy from acceptance until the engine reports done
      if (accept) begin
        busy_q <= 1'b1;
      end else if (eng_done) begin
        busy_q <= 1'b0;
      end
      rsp_valid_q  <= eng_done;
      mult_start_q <= accept & ~req_i.op.mul.is_div;
      div_start_q  <= accept & req_i.op.div.is_div;
    end
  end

  // Held request and the returned result
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q  <= req_i;
      sign_q <= sign_d;
    end
    if (eng_done) begin
      rsp_q.result <= div_done_i ? div_result_i : mult_result_i;
    end
  end

  assign busy_o       = busy_q;
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_o        = rsp_q;
  assign mult_start_o = mult_start_q;
  assign div_start_o  = div_start_q;
  assign op_o         = req_q.op;
  assign op_a_o       = req_q.op_a;
  assign op_b_o       = req_q.op_b;
  assign sign_o       = sign_q;

endmodule

`default_nettype wire

/* rtl/md_mult.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Multiplier engine
// 16x16 multiply-accumulate sequencer for MUL, MULH, MULHSU and MULHU
////////////////////////////////////////////////////////////////////////////

module md_mult (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  md_pkg::md_op_u              op_i,
  input  logic [md_pkg::XLEN-1:0]     op_a_i,
  input  logic [md_pkg::XLEN-1:0]     op_b_i,
  input  md_pkg::md_sign_t            sign_i,
  output logic                        done_o,
  output logic [md_pkg::XLEN-1:0]     result_o
);

  localparam int unsigned HLEN = md_pkg::HLEN;

  typedef enum logic [2:0] {
    M_IDLE,
    M_ALBL,
    M_ALBH,
    M_AHBL,
    M_AHBH
  } mult_state_e;

  mult_state_e        state_q;
  mult_state_e        state_d;

  logic [HLEN-1:0]    mul_a;
  logic [HLEN-1:0]    mul_b;
  logic               sgn_a;
  logic               sgn_b;
  logic [33:0]        accum;
  logic signed [33:0] mac;
  logic [33:0]        acc_q;
  logic [HLEN-1:0]    lo_q;

  logic               is_mul;
  logic               hi_signed;
  logic               a_top;
  logic               b_top;

  assign is_mul    = (op_i.mul.high_mode == md_pkg::MD_HI_MUL);
  assign hi_signed = sign_i.a_signed | sign_i.b_signed;
  // Sign bit of each upper half as a 17-bit operand
  assign a_top     = sign_i.a_signed & op_a_i[md_pkg::XLEN-1];
  assign b_top     = sign_i.b_signed & op_b_i[md_pkg::XLEN-1];

  // 17x17 signed product plus accumulator, the sum always fits 34 bits
  assign mac = $signed({sgn_a, mul_a}) * $signed({sgn_b, mul_b}) + $signed(accum);

  ////////////////////////////////////////////////////////////////////////////
  // Step sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mul_a    = op_a_i[HLEN-1:0];
    mul_b    = op_b_i[HLEN-1:0];
    sgn_a    = 1'b0;
    sgn_b    = 1'b0;
    accum    = '0;
    state_d  = state_q;
    done_o   = 1'b0;
    result_o = mac[md_pkg::XLEN-1:0];

    case (state_q)
      M_IDLE: begin
        if (start_i) begin
          state_d = M_ALBL;
        end
      end
      // al*bl, unsigned with no carry
      M_ALBL: begin
        state_d = M_ALBH;
      end
      // al*bh plus the upper half of al*bl
      M_ALBH: begin
        mul_b   = op_b_i[md_pkg::XLEN-1:HLEN];
        sgn_b   = b_top;
        accum   = {18'b0, acc_q[31:16]};
        state_d = M_AHBL;
      end
      M_AHBL: begin
        mul_a = op_a_i[md_pkg::XLEN-1:HLEN];
        sgn_a = a_top;
        accum = acc_q;
        if (is_mul) begin
          // Only the low half of this sum reaches the low word
          done_o   = 1'b1;
          result_o = {mac[HLEN-1:0], lo_q};
          state_d  = M_IDLE;
        end else begin
          state_d = M_AHBH;
        end
      end
      // ah*bh plus the carried cross terms
      M_AHBH: begin
        mul_a   = op_a_i[md_pkg::XLEN-1:HLEN];
        mul_b   = op_b_i[md_pkg::XLEN-1:HLEN];
        sgn_a   = a_top;
        sgn_b   = b_top;
        accum   = {{16{hi_signed & acc_q[33]}}, acc_q[33:16]};
        done_o  = 1'b1;
        state_d = M_IDLE;
      end
      default: begin
        state_d = M_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= M_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator and the low half kept for MUL
  always_ff @(posedge clk_i) begin
    if (state_q != M_IDLE) begin
      acc_q <= mac;
    end
    if (state_q == M_ALBL) begin
      lo_q <= mac[HLEN-1:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/md_div.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Divider engine
// Restoring long division with its own adder, for DIV, DIVU, REM and REMU
////////////////////////////////////////////////////////////////////////////

module md_div (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  md_pkg::md_op_u              op_i,
  input  logic [md_pkg::XLEN-1:0]     op_a_i,
  input  logic [md_pkg::XLEN-1:0]     op_b_i,
  input  md_pkg::md_sign_t            sign_i,
  output logic                        done_o,
  output logic [md_pkg::XLEN-1:0]     result_o
);

  localparam int unsigned XLEN = md_pkg::XLEN;

  typedef enum logic [2:0] {
    D_IDLE,
    D_ABS_A,
    D_ABS_B,
    D_COMP,
    D_LAST,
    D_CHG_SIGN,
    D_FINISH
  } div_state_e;

  div_state_e       state_q;
  div_state_e       state_d;
  logic [4:0]       cnt_q;
  logic [4:0]       cnt_d;
  logic             zero_q;

  logic [XLEN:0]    add_a;
  logic [XLEN:0]    add_x;
  logic [XLEN:0]    add_res;

  logic [XLEN-1:0]  num_q;
  logic [XLEN-1:0]  den_q;
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  quo_q;
  logic [XLEN-1:0]  res_q;

  logic [XLEN:0]    shifted;
  logic             ge;
  logic             a_neg;
  logic             b_neg;
  logic             res_neg;

  ////////////////////////////////////////////////////////////////////////////
  // Adder and step decision
  ////////////////////////////////////////////////////////////////////////////

  // Computes add_a - add_x in 33 bits
  assign add_res = add_a + ~add_x + {{XLEN{1'b0}}, 1'b1};

  // Partial remainder with the next dividend bit shifted in
  assign shifted = {rem_q, num_q[XLEN-1]};

  // Top bit set means shifted already exceeds any 32-bit divisor
  assign ge = shifted[XLEN] | ~add_res[XLEN];

  assign a_neg   = sign_i.a_signed & op_a_i[XLEN-1];
  assign b_neg   = sign_i.b_signed & op_b_i[XLEN-1];
  // Remainder takes the dividend sign, quotient the sign product
  assign res_neg = op_i.div.is_rem ? a_neg : (a_neg ^ b_neg);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    add_a   = '0;
    add_x   = {1'b0, op_b_i};
    done_o  = 1'b0;

    case (state_q)
      // 0 - b, zero only when b is zero
      D_IDLE: begin
        if (start_i) begin
          state_d = D_ABS_A;
        end
      end
      D_ABS_A: begin
        add_x   = {1'b0, op_a_i};
        state_d = zero_q ? D_FINISH : D_ABS_B;
      end
      D_ABS_B: begin
        cnt_d   = 5'(XLEN - 1);
        state_d = D_COMP;
      end
      // One quotient bit per cycle, MSB first
      D_COMP: begin
        add_a = shifted;
        add_x = {1'b0, den_q};
        if (cnt_q == 5'd0) begin
          state_d = D_LAST;
        end else begin
          cnt_d = cnt_q - 5'd1;
        end
      end
      D_LAST: begin
        state_d = D_CHG_SIGN;
      end
      D_CHG_SIGN: begin
        add_x   = {1'b0, res_q};
        state_d = D_FINISH;
      end
      D_FINISH: begin
        done_o  = 1'b1;
        state_d = D_IDLE;
      end
      default: begin
        state_d = D_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= D_IDLE;
      cnt_q   <= '0;
      zero_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if ((state_q == D_IDLE) && start_i) begin
        zero_q <= (add_res[XLEN-1:0] == '0);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    case (state_q)
      D_IDLE: begin
        // Divide-by-zero result, kept if the divisor turns out zero
        if (start_i) begin
          res_q <= op_i.div.is_rem ? op_a_i : '1;
        end
      end
      D_ABS_A: begin
        num_q <= a_neg ? add_res[XLEN-1:0] : op_a_i;
      end
      D_ABS_B: begin
        den_q <= b_neg ? add_res[XLEN-1:0] : op_b_i;
        rem_q <= '0;
        quo_q <= '0;
      end
      D_COMP: begin
        rem_q <= ge ? add_res[XLEN-1:0] : shifted[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], ge};
        num_q <= {num_q[XLEN-2:0], 1'b0};
      end
      D_LAST: begin
        res_q <= op_i.div.is_rem ? rem_q : quo_q;
      end
      D_CHG_SIGN: begin
        if (res_neg) begin
          res_q <= add_res[XLEN-1:0];
        end
      end
      default: begin
      end
    endcase
  end

  assign result_o = res_q;

endmodule

`default_nettype wire

/* rtl/md_unit.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Multiply/divide unit top level
////////////////////////////////////////////////////////////////////////////

module md_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  input  md_pkg::md_req_t  req_i,
  output logic             busy_o,
  output logic             rsp_valid_o,
  output md_pkg::md_rsp_t  rsp_o
);

  logic                      mult_start;
  logic                      div_start;
  md_pkg::md_op_u            op;
  logic [md_pkg::XLEN-1:0]   op_a;
  logic [md_pkg::XLEN-1:0]   op_b;
  md_pkg::md_sign_t          sign;
  logic                      mult_done;
  logic [md_pkg::XLEN-1:0]   mult_result;
  logic                      div_done;
  logic [md_pkg::XLEN-1:0]   div_result;

  md_ctrl ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .busy_o        (busy_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .mult_start_o  (mult_start),
    .div_start_o   (div_start),
    .op_o          (op),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .sign_o        (sign),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .div_done_i    (div_done),
    .div_result_i  (div_result)
  );

  // Engines share the held operands, only the started one runs
  md_mult mult_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mult_start),
    .op_i     (op),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .sign_i   (sign),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  md_div div_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .op_i     (op),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .sign_i   (sign),
    .done_o   (div_done),
    .result_o (div_result)
  );

endmodule

`default_nettype wire

/* verif/md_checker.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Response checker for the multiply/divide unit
// Queues the expected result of each accepted request and compares responses
////////////////////////////////////////////////////////////////////////////

module md_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  logic                    busy_i,
  input  logic [md_pkg::XLEN-1:0] exp_result_i,
  input  logic                    rsp_valid_i,
  input  md_pkg::md_rsp_t         rsp_i,
  output int                      checked_o,
  output int                      mismatch_o,
  output int                      proto_o,
  output int                      pending_o
);

  logic [md_pkg::XLEN-1:0] exp_q[$];
  logic [md_pkg::XLEN-1:0] exp_head;
  logic                    exp_busy;
  int                      reset_cycles = 0;
  int                      checked_cnt = 0;
  int                      mismatch_cnt = 0;
  int                      proto_cnt = 0;
  int                      pending_cnt = 0;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      // Both strobes low from the second reset cycle on
      if ((reset_cycles > 0) && ((busy_i !== 1'b0) || (rsp_valid_i !== 1'b0))) begin
        proto_cnt++;
        $display("Busy or response strobe is not low during reset at %0t", $time);
      end
      reset_cycles++;
    end else begin
      // Busy from the cycle after acceptance until the response cycle
      exp_busy = (exp_q.size() != 0) && !rsp_valid_i;
      if (busy_i !== exp_busy) begin
        mismatch_cnt++;
        $display("Error: busy_o = 0x%0h, expected 0x%0h at %0t",
                 busy_i, exp_busy, $time);
      end
      // Response before request since both can occur in one cycle
      if (rsp_valid_i) begin
        if (exp_q.size() == 0) begin
          proto_cnt++;
          $display("A response arrived with no request pending at %0t", $time);
        end else begin
          exp_head = exp_q.pop_front();
          checked_cnt++;
          if (rsp_i.result !== exp_head) begin
            mismatch_cnt++;
            $display("Error: rsp_o = 0x%08h, expected 0x%08h (response %0d)",
                     rsp_i.result, exp_head, checked_cnt);
          end
        end
      end
      if (req_valid_i && !busy_i) begin
        exp_q.push_back(exp_result_i);
      end
    end
    pending_cnt = exp_q.size();
  end

  assign checked_o  = checked_cnt;
  assign mismatch_o = mismatch_cnt;
  assign proto_o    = proto_cnt;
  assign pending_o  = pending_cnt;

endmodule

`default_nettype wire

/* verif/tb_md_unit.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply/divide unit, driven from a trace file
////////////////////////////////////////////////////////////////////////////

module tb_md_unit;

  localparam int MAX_OPS      = 64;
  // Idle cycles after the last response that exceed any divide latency
  localparam int DRAIN_CYCLES = 45;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    req_valid;
  md_pkg::md_req_t         req;
  logic                    busy;
  logic                    rsp_valid;
  md_pkg::md_rsp_t         rsp;
  logic [md_pkg::XLEN-1:0] exp_result;

  logic [2:0]              trace_op  [MAX_OPS];
  logic [31:0]             trace_a   [MAX_OPS];
  logic [31:0]             trace_b   [MAX_OPS];
  logic [31:0]             trace_exp [MAX_OPS];
  int                      n_ops = 0;
  int                      seed = 96851;
  logic [31:0]             rnd;
  int                      cycle_cnt = 0;
  int                      cycle_limit = 0;
  int                      run_err_cnt = 0;
  int                      checked_cnt;
  int                      mismatch_cnt;
  int                      proto_cnt;
  int                      pending_cnt;

  md_unit dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid),
    .req_i       (req),
    .busy_o      (busy),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  md_checker checker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .busy_i       (busy),
    .exp_result_i (exp_result),
    .rsp_valid_i  (rsp_valid),
    .rsp_i        (rsp),
    .checked_o    (checked_cnt),
    .mismatch_o   (mismatch_cnt),
    .proto_o      (proto_cnt),
    .pending_o    (pending_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Trace loading, request driving and the closing report
  ////////////////////////////////////////////////////////////////////////////

  // Lines that do not hold four hex fields are comments
  task automatic load_trace();
    int               fd;
    int               n;
    logic [8*160-1:0] line_buf;
    logic [31:0]      f_op;
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [31:0]      f_exp;
    fd = $fopen("verif/md_trace.txt", "r");
    if (fd == 0) begin
      run_err_cnt++;
      $display("Could not open the trace file verif/md_trace.txt");
    end else begin
      while (!$feof(fd) && (n_ops < MAX_OPS)) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) > 0) begin
          n = $sscanf(line_buf, "%h %h %h %h", f_op, f_a, f_b, f_exp);
          if (n == 4) begin
            trace_op[n_ops]  = f_op[2:0];
            trace_a[n_ops]   = f_a;
            trace_b[n_ops]   = f_b;
            trace_exp[n_ops] = f_exp;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_ops == 0) begin
      run_err_cnt++;
      $display("The trace holds no operations");
    end
  endtask

  // Waits on falling edges until the unit is idle, then idles gap cycles
  // and drives one request for one cycle
  task automatic issue_op(input int idx, input int gap);
    while (busy) begin
      @(negedge clk_i);
    end
    repeat (gap) @(negedge clk_i);
    req_valid  = 1'b1;
    req        = {trace_op[idx], trace_a[idx], trace_b[idx]};
    exp_result = trace_exp[idx];
    @(negedge clk_i);
    req_valid  = 1'b0;
  endtask

  task automatic finish_run();
    int total;
    if (pending_cnt != 0) begin
      run_err_cnt++;
      $display("%0d expected results were never returned", pending_cnt);
    end
    total = mismatch_cnt + proto_cnt + run_err_cnt;
    $display("Summary: %0d/%0d checked, %0d mismatches, %0d protocol, %0d run errors",
             checked_cnt, n_ops, mismatch_cnt, proto_cnt, run_err_cnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin
    rst_ni     = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    exp_result = '0;
    load_trace();
    cycle_limit = 40 * n_ops + 100;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < n_ops; i++) begin
      rnd = $random(seed);
      issue_op(i, rnd[1:0]);
    end
    while ((pending_cnt != 0) || busy) begin
      @(negedge clk_i);
    end
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    finish_run();
  end

  // Cycle limit covering reset, every trace line and the drain
  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    run_err_cnt++;
    $display("Run stopped at the cycle limit of %0d cycles", cycle_cnt);
    finish_run();
  end

endmodule

`default_nettype wire

/* verif/md_trace.txt */
# funct3 operand_a operand_b expected, all in hex
# funct3 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 00000007 00000006 0000002A
0 FFFFFFFF FFFFFFFF 00000001
0 80000000 FFFFFFFF 80000000
0 00010001 0000FFFF FFFFFFFF
0 7FFFFFFF 00000002 FFFFFFFE
1 FFFFFFFF FFFFFFFF 00000000
1 80000000 80000000 40000000
1 80000000 00000001 FFFFFFFF
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 00010000 00010000 00000001
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 80000000 FFFFFFFF 80000000
2 00000002 80000000 00000001
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 80000000 80000000 40000000
3 FFFFFFFF 00000002 00000001
4 00000014 00000006 00000003
4 FFFFFFEC 00000006 FFFFFFFD
4 00000014 FFFFFFFA FFFFFFFD
4 80000000 FFFFFFFF 80000000
4 00001234 00000000 FFFFFFFF
5 FFFFFFFF 00000002 7FFFFFFF
5 80000000 00000000 FFFFFFFF
5 00000064 00000007 0000000E
6 FFFFFFEC 00000006 FFFFFFFE
6 00000014 FFFFFFFA 00000002
6 80000000 FFFFFFFF 00000000
6 FFFFFF9C 00000000 FFFFFF9C
7 00000064 00000007 00000002
7 FFFFFFFF 00000000 FFFFFFFF
7 FFFFFFFF 00000010 0000000F
0 FFFFFFFF FFFFFFFF 00000001
4 FFFFFFEC 00000006 FFFFFFFD
3 FFFFFFFF FFFFFFFF FFFFFFFE

/* flist.f */
rtl/md_pkg.sv
rtl/md_ctrl.sv
rtl/md_mult.sv
rtl/md_div.sv
rtl/md_unit.sv
verif/md_checker.sv
verif/tb_md_unit.sv

/* Bender.yml */
package:
  name: md_unit

sources:
  - rtl/md_pkg.sv
  - rtl/md_ctrl.sv
  - rtl/md_mult.sv
  - rtl/md_div.sv
  - rtl/md_unit.sv
  - target: test
    files:
      - verif/md_checker.sv
      - verif/tb_md_unit.sv
